/* project.f */
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/line_renderer.sv
verilog/line_buffer.sv
verilog/clut_ram.sv
verilog/clut_stage.sv
verilog/videogen_top.sv
tb/videogen_checker.sv
tb/videogen_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module videogen_tb -o videogen_sim
./obj_dir/videogen_sim | tee sim.log

if grep -q "\*\*\* PASSED \*\*\*" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* tb/videogen_tb.sv */
`timescale 1ns/1ps

module videogen_tb;

	// Six frames of tests and the palette load, plus slack
	localparam int frame_clocks   = video_pkg::h_total * video_pkg::v_total;
	localparam int timeout_cycles = 6 * frame_clocks + 1200 + 1000;
	localparam int num_tests      = 6;

	logic                    clk_6md = 1'b0;
	logic                    reset;
	logic                    bank;
	logic                    scroll_we;
	video_pkg::pixel_index_t scroll_data;
	logic                    pal_we;
	video_pkg::clut_addr_t   pal_addr;
	logic [7:0]              pal_rg_data;
	video_pkg::colour_t      pal_b_data;
	logic                    hsync;
	logic                    vsync;
	logic                    blank;
	video_pkg::colour_t      red;
	video_pkg::colour_t      green;
	video_pkg::colour_t      blue;

	// Test control and checker status
	logic        check_en;
	logic        test_done;
	int          test_num;
	int          frame_count;
	int          vis_lines;
	int          tests_passed;
	int          tests_failed;
	int          cycles = 0;
	logic [15:0] lfsr_state = 16'd35;

	videogen_top uut (
		.clk_6md     (clk_6md),
		.reset       (reset),
		.bank        (bank),
		.scroll_we   (scroll_we),
		.scroll_data (scroll_data),
		.pal_we      (pal_we),
		.pal_addr    (pal_addr),
		.pal_rg_data (pal_rg_data),
		.pal_b_data  (pal_b_data),
		.hsync       (hsync),
		.vsync       (vsync),
		.blank       (blank),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

	videogen_checker chk (
		.clk_6md      (clk_6md),
		.reset        (reset),
		.bank         (bank),
		.scroll_we    (scroll_we),
		.scroll_data  (scroll_data),
		.pal_we       (pal_we),
		.pal_addr     (pal_addr),
		.pal_rg_data  (pal_rg_data),
		.pal_b_data   (pal_b_data),
		.hsync        (hsync),
		.vsync        (vsync),
		.blank        (blank),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.check_en     (check_en),
		.test_num     (test_num),
		.test_done    (test_done),
		.frame_count  (frame_count),
		.vis_lines    (vis_lines),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed)
	);

	// 10 ns pixel clock
	always #5 clk_6md = ~clk_6md;

	always @(posedge clk_6md) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_step()};
		end
		return v;
	endfunction

	// One entry per clock, both memories at once
	task automatic load_palette();
		for (int a = 0; a < 512; a++) begin
			pal_we      = 1'b1;
			pal_addr    = video_pkg::clut_addr_t'(a);
			pal_rg_data = random_bits(8);
			pal_b_data  = video_pkg::colour_t'(random_bits(4));
			@(negedge clk_6md);
		end
		pal_we = 1'b0;
	endtask

	// Until the next end of vsync at the outputs
	task automatic wait_frame();
		int target;
		target = frame_count + 1;
		while (frame_count < target) begin
			@(posedge clk_6md);
		end
		@(negedge clk_6md);
	endtask

	task automatic end_test();
		test_done = 1'b1;
		@(negedge clk_6md);
		test_done = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset       = 1'b1;
		bank        = 1'b0;
		scroll_we   = 1'b0;
		scroll_data = '0;
		pal_we      = 1'b0;
		pal_addr    = '0;
		pal_rg_data = '0;
		pal_b_data  = '0;
		check_en    = 1'b0;
		test_done   = 1'b0;
		test_num    = 1;
		repeat (2) @(posedge clk_6md);
		@(negedge clk_6md);
		reset = 1'b0;
		// Reset outputs hold one more clock
		repeat (2) @(negedge clk_6md);
		end_test();

		// Raster runs on while the palette loads
		test_num = 2;
		load_palette();
		while (frame_count < 2) begin
			@(posedge clk_6md);
		end
		@(negedge clk_6md);
		end_test();

		test_num = 3;
		check_en = 1'b1;
		wait_frame();
		end_test();

		// Still in vertical blank here
		test_num = 4;
		bank     = 1'b1;
		wait_frame();
		end_test();

		// Strobe in the middle of the picture
		test_num = 5;
		while (vis_lines < 4) begin
			@(posedge clk_6md);
		end
		@(negedge clk_6md);
		scroll_we   = 1'b1;
		scroll_data = random_bits(8) | 8'h01;
		@(negedge clk_6md);
		scroll_we = 1'b0;
		wait_frame();
		wait_frame();
		end_test();

		test_num = 6;
		check_en = 1'b0;
		wait_frame();
		end_test();

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && tests_passed == num_tests) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tb/videogen_checker.sv */
`timescale 1ns/1ps

module videogen_checker (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  logic                    bank,
	input  logic                    scroll_we,
	input  video_pkg::pixel_index_t scroll_data,
	input  logic                    pal_we,
	input  video_pkg::clut_addr_t   pal_addr,
	input  logic [7:0]              pal_rg_data,
	input  video_pkg::colour_t      pal_b_data,
	input  logic                    hsync,
	input  logic                    vsync,
	input  logic                    blank,
	input  video_pkg::colour_t      red,
	input  video_pkg::colour_t      green,
	input  video_pkg::colour_t      blue,
	input  logic                    check_en,
	input  int                      test_num,
	input  logic                    test_done,
	output int                      frame_count,
	output int                      vis_lines,
	output int                      tests_passed,
	output int                      tests_failed
);

	// Palette and scroll as loaded through the input strobes
	logic [7:0]              pal_rg [512];
	video_pkg::colour_t      pal_b [512];
	video_pkg::pixel_index_t scroll_pending;
	video_pkg::pixel_index_t scroll_active;

	// Inputs as seen at the last rising edge
	logic reset_q = 1'b1;
	logic bank_q;
	logic check_q;

	// Raster position recovered from the outputs
	logic        prev_reset;
	logic        prev_hs;
	logic        prev_vs;
	logic        prev_blank;
	int          cyc;
	int          last_hs_rise = -1;
	int          vs_len;
	int          col;
	int          scan_line;
	logic [11:0] exp_rgb;

	// Sample kinds: 0 reset, 1 hsync period, 2 pixel, 3 blank
	int err_total;
	int samples [4];
	int err_mark;
	int sample_mark [4];
	int errs;
	int seen;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Gradient index through the palette, packed as red, green, blue
	function automatic logic [11:0] expected_rgb(input logic bnk, input int line_no,
		input int col_no, input video_pkg::pixel_index_t scr);
		video_pkg::pixel_index_t idx;
		video_pkg::clut_addr_t   addr;
		idx  = video_pkg::pixel_index_t'((16 * line_no + col_no + int'(scr)) % 256);
		addr = {bnk, idx};
		return {pal_rg[addr][3:0], pal_rg[addr][7:4], pal_b[addr]};
	endfunction

	function automatic int sample_kind(input int n);
		case (n)
			1: return 0;
			2: return 1;
			6: return 3;
			default: return 2;
		endcase
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "raster";
			3: return "bank 0 lookup";
			4: return "bank 1 lookup";
			5: return "scroll";
			default: return "blanking";
		endcase
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("error t=%0t signal=%s expected=%0d actual=%0d",
				$time, name, expected, actual);
			err_total++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Input mirrors
	////////////////////////////////////////////////////////////

	always @(posedge clk_6md) begin
		reset_q <= reset;
		bank_q  <= bank;
		check_q <= check_en;
		if (reset) begin
			scroll_pending <= '0;
		end else if (scroll_we) begin
			scroll_pending <= scroll_data;
		end
		// Same edge as the DUT write
		if (pal_we) begin
			pal_rg[pal_addr] <= pal_rg_data;
			pal_b[pal_addr]  <= pal_b_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Output checks, half a clock after the outputs change
	////////////////////////////////////////////////////////////

	always @(negedge clk_6md) begin
		if (reset_q || prev_reset) begin
			// Reset and the first clock after it
			check_value("blank", 1, int'(blank));
			check_value("hsync", 0, int'(hsync));
			check_value("vsync", 0, int'(vsync));
			check_value("red", 0, int'(red));
			check_value("green", 0, int'(green));
			check_value("blue", 0, int'(blue));
			samples[0]++;
			cyc           = 0;
			last_hs_rise  = -1;
			vs_len        = 0;
			vis_lines     = 0;
			col           = 0;
			scroll_active = '0;
			prev_hs       = 1'b0;
			prev_vs       = 1'b0;
			prev_blank    = 1'b1;
		end else begin
			cyc++;
			// Line length from hsync to hsync
			if (hsync && !prev_hs) begin
				if (last_hs_rise >= 0) begin
					check_value("hsync period", video_pkg::h_total, cyc - last_hs_rise);
					samples[1]++;
				end
				last_hs_rise = cyc;
			end
			if (vsync) begin
				vs_len++;
			end
			if (vsync && !prev_vs) begin
				check_value("visible lines", video_pkg::v_active, vis_lines);
			end
			// End of vsync starts a new frame, scroll handed over with it
			if (!vsync && prev_vs) begin
				check_value("vsync length", video_pkg::h_total, vs_len);
				vs_len        = 0;
				vis_lines     = 0;
				scan_line     = 0;
				scroll_active = scroll_pending;
				frame_count++;
			end
			// A visible run just ended
			if (blank && !prev_blank) begin
				check_value("visible run", video_pkg::h_active, col);
				col = 0;
				scan_line++;
				vis_lines++;
			end
			if (blank) begin
				check_value("red", 0, int'(red));
				check_value("green", 0, int'(green));
				check_value("blue", 0, int'(blue));
				samples[3]++;
			end else begin
				// Line count is only known after the first vsync
				if (check_q && frame_count > 0) begin
					exp_rgb = expected_rgb(bank_q, scan_line, col, scroll_active);
					check_value("red", int'(exp_rgb[11:8]), int'(red));
					check_value("green", int'(exp_rgb[7:4]), int'(green));
					check_value("blue", int'(exp_rgb[3:0]), int'(blue));
					samples[2]++;
				end
				col++;
			end
			prev_hs    = hsync;
			prev_vs    = vsync;
			prev_blank = blank;
		end
		prev_reset = reset_q;
	end

	////////////////////////////////////////////////////////////
	// Per-test summary
	////////////////////////////////////////////////////////////

	always @(posedge clk_6md) begin
		if (test_done) begin
			errs = err_total - err_mark;
			seen = samples[sample_kind(test_num)] - sample_mark[sample_kind(test_num)];
			if (seen == 0) begin
				$display("test %0d %s: failed, nothing was checked before the test ended",
					test_num, test_name(test_num));
				tests_failed++;
			end else if (errs != 0) begin
				$display("test %0d %s: failed with %0d errors", test_num,
					test_name(test_num), errs);
				tests_failed++;
			end else begin
				$display("test %0d %s: passed, %0d samples", test_num,
					test_name(test_num), seen);
				tests_passed++;
			end
			err_mark    = err_total;
			sample_mark = samples;
		end
	end

endmodule

/* verilog/videogen_top.sv */
`timescale 1ns/1ps

module videogen_top (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  logic                    bank,
	input  logic                    scroll_we,
	input  video_pkg::pixel_index_t scroll_data,
	input  logic                    pal_we,
	input  video_pkg::clut_addr_t   pal_addr,
	input  logic [7:0]              pal_rg_data,
	input  video_pkg::colour_t      pal_b_data,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    blank,
	output video_pkg::colour_t      red,
	output video_pkg::colour_t      green,
	output video_pkg::colour_t      blue
);

	////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////

	// Raster position
	video_pkg::hcount_t      hcount;
	video_pkg::vcount_t      vcount;
	logic                    visible;
	logic                    hsync_raw;
	logic                    vsync_raw;

	// Renderer to line buffer
	logic                    wr_en;
	video_pkg::hcount_t      wr_addr;
	video_pkg::pixel_index_t wr_index;

	// Line buffer to lookup
	video_pkg::pixel_index_t rd_index;

	// Lookup memories
	video_pkg::clut_addr_t   clut_addr;
	logic [7:0]              rg_data;
	video_pkg::colour_t      b_data;

	video_timing timing (
		.clk_6md   (clk_6md),
		.reset     (reset),
		.hcount    (hcount),
		.vcount    (vcount),
		.visible   (visible),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	line_renderer renderer (
		.clk_6md     (clk_6md),
		.reset       (reset),
		.hcount      (hcount),
		.vcount      (vcount),
		.scroll_we   (scroll_we),
		.scroll_data (scroll_data),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_index    (wr_index)
	);

	// Scan position doubles as read address
	line_buffer linebuf (
		.clk_6md  (clk_6md),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_index (wr_index),
		.rd_addr  (hcount),
		.vcount   (vcount),
		.rd_index (rd_index)
	);

	clut_stage clut (
		.clk_6md   (clk_6md),
		.reset     (reset),
		.index     (rd_index),
		.bank      (bank),
		.visible   (visible),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.clut_addr (clut_addr),
		.rg_data   (rg_data),
		.b_data    (b_data),
		.hsync     (hsync),
		.vsync     (vsync),
		.blank     (blank),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

	// Red and green share one memory
	clut_ram #(.data_width(8)) rg_ram (
		.clk_6md (clk_6md),
		.we      (pal_we),
		.waddr   (pal_addr),
		.wdata   (pal_rg_data),
		.raddr   (clut_addr),
		.rdata   (rg_data)
	);

	clut_ram #(.data_width(4)) b_ram (
		.clk_6md (clk_6md),
		.we      (pal_we),
		.waddr   (pal_addr),
		.wdata   (pal_b_data),
		.raddr   (clut_addr),
		.rdata   (b_data)
	);

endmodule

/* verilog/clut_stage.sv */
`timescale 1ns/1ps

module clut_stage (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  video_pkg::pixel_index_t index,
	input  logic                    bank,
	input  logic                    visible,
	input  logic                    hsync_raw,
	input  logic                    vsync_raw,
	output video_pkg::clut_addr_t   clut_addr,
	input  logic [7:0]              rg_data,
	input  video_pkg::colour_t      b_data,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    blank,
	output video_pkg::colour_t      red,
	output video_pkg::colour_t      green,
	output video_pkg::colour_t      blue
);

	// Timing side band, oldest stage on top
	logic [video_pkg::clut_delay-1:0] hs_pipe;
	logic [video_pkg::clut_delay-1:0] vs_pipe;
	logic [video_pkg::clut_delay-1:0] vis_pipe;

	////////////////////////////////////////////////////////////
	// Index latch
	////////////////////////////////////////////////////////////

	// Bank bit above the 8-bit index
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			clut_addr <= '0;
		end else begin
			clut_addr <= {bank, index};
		end
	end

	////////////////////////////////////////////////////////////
	// Colour output registers
	////////////////////////////////////////////////////////////

	// Stage 1 of the pipe lines up with the latched index
	always_ff @(posedge clk_6md) begin
		if (reset || !vis_pipe[video_pkg::clut_delay-2]) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else begin
			// Red low, green high
			red   <= rg_data[3:0];
			green <= rg_data[7:4];
			blue  <= b_data;
		end
	end

	// Sync and blank delay
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			hs_pipe  <= '0;
			vs_pipe  <= '0;
			vis_pipe <= '0;
		end else begin
			hs_pipe  <= {hs_pipe[video_pkg::clut_delay-2:0], hsync_raw};
			vs_pipe  <= {vs_pipe[video_pkg::clut_delay-2:0], vsync_raw};
			vis_pipe <= {vis_pipe[video_pkg::clut_delay-2:0], visible};
		end
	end

	assign hsync = hs_pipe[video_pkg::clut_delay-1];
	assign vsync = vs_pipe[video_pkg::clut_delay-1];
	assign blank = ~vis_pipe[video_pkg::clut_delay-1];

endmodule

/* verilog/clut_ram.sv */
`timescale 1ns/1ps

module clut_ram #(
	parameter int data_width = 8
) (
	input  logic                  clk_6md,
	input  logic                  we,
	input  video_pkg::clut_addr_t waddr,
	input  logic [data_width-1:0] wdata,
	input  video_pkg::clut_addr_t raddr,
	output logic [data_width-1:0] rdata
);

	// One entry per bank and index
	logic [data_width-1:0] mem [2**$bits(video_pkg::clut_addr_t)];

	////////////////////////////////////////////////////////////
	// Palette load port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Lookup port
	////////////////////////////////////////////////////////////

	// Asynchronous, as on the PROM
	assign rdata = mem[raddr];

endmodule

/* verilog/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  logic                    wr_en,
	input  video_pkg::hcount_t      wr_addr,
	input  video_pkg::pixel_index_t wr_index,
	input  video_pkg::hcount_t      rd_addr,
	input  video_pkg::vcount_t      vcount,
	output video_pkg::pixel_index_t rd_index
);

	// Two halves, swapped every line
	video_pkg::pixel_index_t mem0 [video_pkg::h_active];
	video_pkg::pixel_index_t mem1 [video_pkg::h_active];

	logic rd_half;
	logic wr_in_range;
	logic rd_in_range;

	// Odd lines read half 1
	assign rd_half = vcount[0];

	assign wr_in_range = (wr_addr < video_pkg::hcount_t'(video_pkg::h_active));
	assign rd_in_range = (rd_addr < video_pkg::hcount_t'(video_pkg::h_active));

	////////////////////////////////////////////////////////////
	// Write side, the half not on screen
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (wr_en && wr_in_range) begin
			if (rd_half) begin
				mem0[wr_addr[video_pkg::h_addr_w-1:0]] <= wr_index;
			end else begin
				mem1[wr_addr[video_pkg::h_addr_w-1:0]] <= wr_index;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read side, registered
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			rd_index <= '0;
		end else if (!rd_in_range) begin
			// Blanking columns read as index 0
			rd_index <= '0;
		end else if (rd_half) begin
			rd_index <= mem1[rd_addr[video_pkg::h_addr_w-1:0]];
		end else begin
			rd_index <= mem0[rd_addr[video_pkg::h_addr_w-1:0]];
		end
	end

	// A write never lands after the halves swap
	assert property (@(posedge clk_6md) disable iff (reset)
		wr_en |-> (vcount == $past(vcount)))
		else $error("line buffer write into the half being read");

endmodule

/* verilog/line_renderer.sv */
`timescale 1ns/1ps

module line_renderer (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  video_pkg::hcount_t      hcount,
	input  video_pkg::vcount_t      vcount,
	input  logic                    scroll_we,
	input  video_pkg::pixel_index_t scroll_data,
	output logic                    wr_en,
	output video_pkg::hcount_t      wr_addr,
	output video_pkg::pixel_index_t wr_index
);

	// Line being drawn, one ahead of the scan
	video_pkg::vcount_t      next_line;
	logic                    line_zero_start;
	logic                    draw;
	video_pkg::pixel_index_t scroll_pending;
	video_pkg::pixel_index_t scroll_active;
	video_pkg::pixel_index_t scroll_now;
	video_pkg::pixel_index_t gradient;

	assign next_line = (vcount == video_pkg::vcount_t'(video_pkg::v_total - 1)) ?
		'0 : vcount + 1'b1;

	// First pixel of line 0 of a new frame
	assign line_zero_start = (hcount == '0) && (next_line == '0);

	// Only visible columns of visible lines
	assign draw = (hcount < video_pkg::hcount_t'(video_pkg::h_active)) &&
		(next_line < video_pkg::vcount_t'(video_pkg::v_active));

	// New scroll already applies to the first pixel of line 0
	assign scroll_now = line_zero_start ? scroll_pending : scroll_active;

	////////////////////////////////////////////////////////////
	// Gradient stand-in for the tile layers
	////////////////////////////////////////////////////////////

	// 16 x line + column + scroll, wraps at 256
	assign gradient = {next_line, 4'b0000} +
		video_pkg::pixel_index_t'(hcount) + scroll_now;

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			scroll_pending <= '0;
			scroll_active  <= '0;
			wr_en          <= 1'b0;
		end else begin
			if (scroll_we) begin
				scroll_pending <= scroll_data;
			end
			// Hand over once per frame
			if (line_zero_start) begin
				scroll_active <= scroll_pending;
			end
			wr_en <= draw;
		end
	end

	// Write data, one clock behind the counters
	always_ff @(posedge clk_6md) begin
		wr_addr  <= hcount;
		wr_index <= gradient;
	end

	// Last write lands as the scan steps past the visible columns
	assert property (@(posedge clk_6md) disable iff (reset)
		wr_en |-> (hcount <= video_pkg::hcount_t'(video_pkg::h_active)))
		else $error("renderer write outside the visible columns");

endmodule

/* verilog/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
	input  logic               clk_6md,
	input  logic               reset,
	output video_pkg::hcount_t hcount,
	output video_pkg::vcount_t vcount,
	output logic               visible,
	output logic               hsync_raw,
	output logic               vsync_raw
);

	// Last column and last line of the raster
	logic line_end;
	logic frame_end;

	assign line_end  = (hcount == video_pkg::hcount_t'(video_pkg::h_total - 1));
	assign frame_end = (vcount == video_pkg::vcount_t'(video_pkg::v_total - 1));

	////////////////////////////////////////////////////////////
	// Free running raster counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			// Wrap column, step line
			hcount <= '0;
			if (frame_end) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 1'b1;
			end
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Window decode
	////////////////////////////////////////////////////////////

	// Active picture area
	assign visible = (hcount < video_pkg::hcount_t'(video_pkg::h_active)) &&
		(vcount < video_pkg::vcount_t'(video_pkg::v_active));

	// Hsync window inside horizontal blank
	assign hsync_raw = (hcount >= video_pkg::hcount_t'(video_pkg::h_sync_start)) &&
		(hcount < video_pkg::hcount_t'(video_pkg::h_sync_start + video_pkg::h_sync_len));

	// One whole line of vsync
	assign vsync_raw = (vcount == video_pkg::vcount_t'(video_pkg::v_sync_line));

	// Column counter wraps before the line length
	assert property (@(posedge clk_6md)
		hcount < video_pkg::hcount_t'(video_pkg::h_total))
		else $error("hcount reached h_total");

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////////////////////////
	// Raster geometry
	////////////////////////////////////////////////////////////

	// Visible pixels per line
	localparam int h_active = 32;
	// Clocks per line, visible plus blanking
	localparam int h_total = 48;
	// First column of hsync
	localparam int h_sync_start = 36;
	// Hsync width in clocks
	localparam int h_sync_len = 4;

	// Visible lines per frame
	localparam int v_active = 8;
	// Lines per frame
	localparam int v_total = 12;
	// Line with vsync high
	localparam int v_sync_line = 10;

	// Counter position to RGB pins
	localparam int clut_delay = 3;

	// Line buffer address bits
	localparam int h_addr_w = $clog2(h_active);

	////////////////////////////////////////////////////////////
	// Pixel path types
	////////////////////////////////////////////////////////////

	typedef logic [7:0] pixel_index_t;
	typedef logic [3:0] colour_t;
	// Bank bit on top of the index
	typedef logic [8:0] clut_addr_t;
	typedef logic [5:0] hcount_t;
	typedef logic [3:0] vcount_t;

endpackage
